/* Makefile */
TOP := tb_ex_stage
OBJ := obj_dir

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ns -f build.f --top-module ex_stage
	verilator --lint-only --timing --timescale 1ns/1ns -f build.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert --timescale 1ns/1ns -f build.f \
		--top-module $(TOP) --Mdir $(OBJ)
	./$(OBJ)/V$(TOP)

clean:
	rm -rf $(OBJ)

/* build.f */
+incdir+rtl
rtl/ex_pkg.sv
rtl/ex_alu.sv
rtl/ex_branch_unit.sv
rtl/ex_stage.sv
testbench/ex_stage_checker.sv
testbench/tb_ex_stage.sv

/* rtl/ex_alu.sv */
// Execute stage ALU

`timescale 1ns/1ns
`default_nettype none

`include "ex_cfg.svh"

module ex_alu (
  input  logic [`EX_XLEN-1:0] operand_a_i,
  input  logic [`EX_XLEN-1:0] operand_b_i,
  input  ex_pkg::alu_op_e     alu_op_i,
  output logic [`EX_XLEN-1:0] result_o,
  output logic                cmp_result_o
);

  import ex_pkg::*;

  ////////////////////////////////////////////////////////////////////////////
  // Shared arithmetic
  ////////////////////////////////////////////////////////////////////////////

  logic [`EX_XLEN-1:0] add_result;
  logic [`EX_XLEN-1:0] sub_result;
  logic [`EX_XLEN-1:0] sra_result;
  logic [4:0]          shamt;
  logic                is_equal;
  logic                less_signed;
  logic                less_unsigned;

  // Only the low five bits of operand b count as shift amount
  assign shamt = operand_b_i[4:0];

  assign add_result = operand_a_i + operand_b_i;
  assign sub_result = operand_a_i - operand_b_i;

  // Arithmetic right shift keeps the sign of operand a
  assign sra_result = $unsigned($signed(operand_a_i) >>> shamt);

  // One set of comparators serves SLT/SLTU and all branch compares
  assign is_equal      = (operand_a_i == operand_b_i);
  assign less_signed   = ($signed(operand_a_i) < $signed(operand_b_i));
  assign less_unsigned = (operand_a_i < operand_b_i);

  ////////////////////////////////////////////////////////////////////////////
  // Branch comparison
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (alu_op_i)
      ALU_EQ:  cmp_result_o = is_equal;
      ALU_NE:  cmp_result_o = !is_equal;
      ALU_LT:  cmp_result_o = less_signed;
      ALU_GE:  cmp_result_o = !less_signed;
      ALU_LTU: cmp_result_o = less_unsigned;
      ALU_GEU: cmp_result_o = !less_unsigned;
      // Not a compare, so no branch condition is reported
      default: cmp_result_o = 1'b0;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Result select
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    case (alu_op_i)
      ALU_ADD:  result_o = add_result;
      ALU_SUB:  result_o = sub_result;
      ALU_AND:  result_o = operand_a_i & operand_b_i;
      ALU_OR:   result_o = operand_a_i | operand_b_i;
      ALU_XOR:  result_o = operand_a_i ^ operand_b_i;
      ALU_SLT:  result_o = {{(`EX_XLEN-1){1'b0}}, less_signed};
      ALU_SLTU: result_o = {{(`EX_XLEN-1){1'b0}}, less_unsigned};
      ALU_SLL:  result_o = operand_a_i << shamt;
      ALU_SRL:  result_o = operand_a_i >> shamt;
      ALU_SRA:  result_o = sra_result;
      // The six compares return their flag zero extended
      default:  result_o = {{(`EX_XLEN-1){1'b0}}, cmp_result_o};
    endcase
  end

endmodule

`default_nettype wire

/* rtl/ex_branch_unit.sv */
// Conditional branch resolution

`timescale 1ns/1ns
`default_nettype none

`include "ex_cfg.svh"

module ex_branch_unit (
  input  logic                branch_i,
  input  logic                compressed_i,
  input  logic                cmp_result_i,
  input  logic                dataindtiming_i,
  input  logic [`EX_XLEN-1:0] pc_i,
  input  logic [11:0]         branch_offset_i,
  output logic                branch_decision_o,
  output logic [`EX_XLEN-1:0] branch_target_o
);

  logic [`EX_XLEN-1:0] offset_ext;
  logic [`EX_XLEN-1:0] taken_target;
  logic [`EX_XLEN-1:0] seq_target;
  logic [2:0]          seq_step;

  ////////////////////////////////////////////////////////////////////////////
  // Target addresses
  ////////////////////////////////////////////////////////////////////////////

  // Offset is in halfwords, so sign extend and append a zero
  assign offset_ext = {{(`EX_XLEN-13){branch_offset_i[11]}}, branch_offset_i, 1'b0};

  assign taken_target = pc_i + offset_ext;

  // Next sequential instruction depends on the encoding size
  assign seq_step   = compressed_i ? 3'd2 : 3'd4;
  assign seq_target = pc_i + {{(`EX_XLEN-3){1'b0}}, seq_step};

  ////////////////////////////////////////////////////////////////////////////
  // Decision
  ////////////////////////////////////////////////////////////////////////////

  // In data independent timing mode the branch is always taken
  // An untaken one then jumps to its own fall-through address
  assign branch_decision_o = branch_i && (cmp_result_i || dataindtiming_i);

  always_comb begin
    if (dataindtiming_i && !cmp_result_i) begin
      // Same redirect path as a taken branch, but lands on the next instruction
      branch_target_o = seq_target;
    end else begin
      branch_target_o = taken_target;
    end
  end

endmodule

`default_nettype wire

/* rtl/ex_cfg.svh */
// Execute stage configuration

`ifndef EX_CFG_SVH
`define EX_CFG_SVH

////////////////////////////////////////////////////////////////////////////
// Datapath sizing
////////////////////////////////////////////////////////////////////////////

// Width of register operands, results and addresses
`define EX_XLEN 32

////////////////////////////////////////////////////////////////////////////
// Optional features
////////////////////////////////////////////////////////////////////////////

// Build in the coprocessor extension interface by default
// Set to 1'b0 for a core without an external coprocessor
`define EX_X_EXT_DEFAULT 1'b1

`endif

/* rtl/ex_pkg.sv */
// Execute stage types

`default_nettype none

`include "ex_cfg.svh"

package ex_pkg;

  //////////////////////////////////////////////////////////////////////////
  // ALU operations
  //////////////////////////////////////////////////////////////////////////

  // The last six encodings are the branch comparisons
  typedef enum logic [3:0] {
    ALU_ADD  = 4'd0,
    ALU_SUB  = 4'd1,
    ALU_AND  = 4'd2,
    ALU_OR   = 4'd3,
    ALU_XOR  = 4'd4,
    ALU_SLT  = 4'd5,
    ALU_SLTU = 4'd6,
    ALU_SLL  = 4'd7,
    ALU_SRL  = 4'd8,
    ALU_SRA  = 4'd9,
    ALU_EQ   = 4'd10,
    ALU_NE   = 4'd11,
    ALU_LT   = 4'd12,
    ALU_GE   = 4'd13,
    ALU_LTU  = 4'd14,
    ALU_GEU  = 4'd15
  } alu_op_e;

  //////////////////////////////////////////////////////////////////////////
  // Security and controller requests
  //////////////////////////////////////////////////////////////////////////

  // Data independent timing forces every branch onto the taken path
  typedef struct packed {
    logic dataindtiming;
  } cpuctrl_t;

  typedef struct packed {
    cpuctrl_t cpuctrl;
  } xsecure_ctrl_t;

  // Kill wins over halt when both are raised by the controller
  typedef struct packed {
    logic halt_ex;
    logic kill_ex;
  } ctrl_fsm_t;

  //////////////////////////////////////////////////////////////////////////
  // Pipeline registers
  //////////////////////////////////////////////////////////////////////////

  // Coprocessor offload result as seen from the core
  typedef struct packed {
    logic accepted;
  } xif_meta_t;

  typedef struct packed {
    logic branch;
    logic compressed;
  } instr_meta_t;

  // Everything decode hands over to execute
  typedef struct packed {
    logic                instr_valid;
    logic [`EX_XLEN-1:0] pc;
    logic [`EX_XLEN-1:0] operand_a;
    logic [`EX_XLEN-1:0] operand_b;
    logic [11:0]         branch_offset;
    alu_op_e             alu_op;
    logic                alu_en;
    logic                lsu_en;
    logic                csr_en;
    logic                rf_we;
    logic                xif_en;
    xif_meta_t           xif_meta;
    instr_meta_t         instr_meta;
  } id_ex_pipe_t;

  // Everything execute hands over to writeback
  typedef struct packed {
    logic                instr_valid;
    logic                rf_we;
    logic                csr_en;
    logic                lsu_en;
    logic [`EX_XLEN-1:0] result;
    logic                branch_taken;
    logic                split;
  } ex_wb_pipe_t;

endpackage

`default_nettype wire

/* rtl/ex_stage.sv */
// Execute stage top level

`timescale 1ns/1ns
`default_nettype none

`include "ex_cfg.svh"

module ex_stage #(
  parameter bit X_EXT = `EX_X_EXT_DEFAULT
) (
  input  logic                  clk,
  input  logic                  reset_i,

  // Instruction from the ID/EX pipe
  input  ex_pkg::id_ex_pipe_t   id_ex_pipe_i,

  // Controller and security state
  input  ex_pkg::ctrl_fsm_t     ctrl_fsm_i,
  input  ex_pkg::xsecure_ctrl_t xsecure_ctrl_i,
  input  logic                  csr_illegal_i,
  input  logic                  lsu_split_i,

  // Handshake towards ID and WB
  input  logic                  wb_ready_i,
  output logic                  ex_ready_o,
  output logic                  ex_valid_o,

  // Branch redirect to the fetch stage
  output logic                  branch_decision_o,
  output logic [`EX_XLEN-1:0]   branch_target_o,

  // EX/WB pipe register
  output ex_pkg::ex_wb_pipe_t   ex_wb_pipe_o
);

  import ex_pkg::*;

  // Handshake
  logic                halt_ex;
  logic                kill_ex;
  logic                transfer;

  // Datapath
  logic [`EX_XLEN-1:0] alu_result;
  logic                alu_cmp_result;
  logic [`EX_XLEN-1:0] lsu_addr;
  logic [`EX_XLEN-1:0] ex_result;

  // Write enable suppression
  logic                xif_accepted;
  logic                split_first;
  logic                csr_en_ex;
  logic                rf_we_ex;

  // EX/WB register contents
  logic                wb_valid_q;
  logic                wb_rf_we_q;
  logic                wb_csr_en_q;
  logic                wb_lsu_en_q;
  logic                wb_branch_taken_q;
  logic                wb_split_q;
  logic [`EX_XLEN-1:0] wb_result_q;

  ////////////////////////////////////////////////////////////////////////////
  // Handshake
  ////////////////////////////////////////////////////////////////////////////

  assign halt_ex = ctrl_fsm_i.halt_ex;
  assign kill_ex = ctrl_fsm_i.kill_ex;

  // Kill drops the instruction, so ID may move on while nothing goes to WB
  // Halt freezes the stage and holds the instruction in ID/EX
  assign ex_ready_o = kill_ex || (!halt_ex && wb_ready_i);
  assign ex_valid_o = id_ex_pipe_i.instr_valid && !halt_ex && !kill_ex;

  // An instruction moves into EX/WB only when both sides agree
  assign transfer = ex_valid_o && wb_ready_i;

  ////////////////////////////////////////////////////////////////////////////
  // ALU and branch unit
  ////////////////////////////////////////////////////////////////////////////

  ex_alu u_alu (
    .operand_a_i  (id_ex_pipe_i.operand_a),
    .operand_b_i  (id_ex_pipe_i.operand_b),
    .alu_op_i     (id_ex_pipe_i.alu_op),
    .result_o     (alu_result),
    .cmp_result_o (alu_cmp_result)
  );

  // Branches resolve combinationally in the same cycle as the instruction
  ex_branch_unit u_branch_unit (
    .branch_i          (id_ex_pipe_i.instr_meta.branch),
    .compressed_i      (id_ex_pipe_i.instr_meta.compressed),
    .cmp_result_i      (alu_cmp_result),
    .dataindtiming_i   (xsecure_ctrl_i.cpuctrl.dataindtiming),
    .pc_i              (id_ex_pipe_i.pc),
    .branch_offset_i   (id_ex_pipe_i.branch_offset),
    .branch_decision_o (branch_decision_o),
    .branch_target_o   (branch_target_o)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Result select
  ////////////////////////////////////////////////////////////////////////////

  // Loads and stores always address with base plus offset
  // whatever ALU operation decode happened to select
  assign lsu_addr  = id_ex_pipe_i.operand_a + id_ex_pipe_i.operand_b;
  assign ex_result = id_ex_pipe_i.lsu_en ? lsu_addr : alu_result;

  ////////////////////////////////////////////////////////////////////////////
  // Write enable suppression
  ////////////////////////////////////////////////////////////////////////////

  // A coprocessor that accepted the instruction owns its CSR side effects
  // Without the extension interface nothing can be accepted externally
  assign xif_accepted = X_EXT && id_ex_pipe_i.xif_en && id_ex_pipe_i.xif_meta.accepted;

  // Illegal CSR accesses must never reach the CSR file
  assign csr_en_ex = id_ex_pipe_i.csr_en && !csr_illegal_i && !xif_accepted;

  // First half of a misaligned access carries no load data
  assign split_first = id_ex_pipe_i.lsu_en && lsu_split_i;
  assign rf_we_ex    = id_ex_pipe_i.rf_we && !split_first;

  ////////////////////////////////////////////////////////////////////////////
  // EX/WB pipe register
  ////////////////////////////////////////////////////////////////////////////

  // Control bits are cleared by reset
  always_ff @(posedge clk) begin
    if (reset_i) begin
      wb_valid_q        <= 1'b0;
      wb_rf_we_q        <= 1'b0;
      wb_csr_en_q       <= 1'b0;
      wb_lsu_en_q       <= 1'b0;
      wb_branch_taken_q <= 1'b0;
      wb_split_q        <= 1'b0;
    end else if (transfer) begin
      wb_valid_q        <= 1'b1;
      wb_rf_we_q        <= rf_we_ex;
      wb_csr_en_q       <= csr_en_ex;
      wb_lsu_en_q       <= id_ex_pipe_i.lsu_en;
      wb_branch_taken_q <= branch_decision_o;
      wb_split_q        <= split_first;
    end else if (wb_ready_i) begin
      // WB consumed the old entry and nothing new arrived
      wb_valid_q <= 1'b0;
    end
  end

  // Result word only loads on a transfer
  always_ff @(posedge clk) begin
    if (transfer) begin
      wb_result_q <= ex_result;
    end
  end

  // Under back-pressure none of the registers above change
  assign ex_wb_pipe_o = '{
    instr_valid:  wb_valid_q,
    rf_we:        wb_rf_we_q,
    csr_en:       wb_csr_en_q,
    lsu_en:       wb_lsu_en_q,
    result:       wb_result_q,
    branch_taken: wb_branch_taken_q,
    split:        wb_split_q
  };

endmodule

`default_nettype wire

/* testbench/ex_stage_checker.sv */
// Execute stage protocol checker

`timescale 1ns/1ns
`default_nettype none

`include "ex_cfg.svh"

module ex_stage_checker #(
  parameter bit X_EXT = `EX_X_EXT_DEFAULT
) (
  input  logic                  clk,
  input  logic                  reset_i,
  input  ex_pkg::id_ex_pipe_t   id_ex_pipe_i,
  input  ex_pkg::ctrl_fsm_t     ctrl_fsm_i,
  input  ex_pkg::xsecure_ctrl_t xsecure_ctrl_i,
  input  logic                  csr_illegal_i,
  input  logic                  lsu_split_i,
  input  logic                  wb_ready_i,
  input  logic                  ex_ready_i,
  input  logic                  ex_valid_i,
  input  logic                  branch_decision_i,
  input  logic [`EX_XLEN-1:0]   branch_target_i,
  input  ex_pkg::ex_wb_pipe_t   ex_wb_pipe_i,
  // Reference model values from the testbench
  input  logic [`EX_XLEN-1:0]   exp_result_i,
  input  logic                  exp_cmp_i,
  output logic                  error_o
);

  import ex_pkg::*;

  logic                failed = 1'b0;
  logic                seen_edge = 1'b0;
  logic                prev_reset = 1'b0;
  logic                prev_transfer = 1'b0;
  logic                prev_kill = 1'b0;
  logic                prev_wb_ready = 1'b0;
  logic                prev_dit = 1'b0;
  ex_wb_pipe_t         prev_wb;
  ex_wb_pipe_t         exp_wb;
  logic                dit;
  logic [`EX_XLEN-1:0] exp_target;

  assign error_o = failed;
  assign dit     = xsecure_ctrl_i.cpuctrl.dataindtiming;

  // Only the first failure is printed
  task automatic report_error(input string msg);
    if (!failed) begin
      $display("Error at %0t ns: %s", $time, msg);
    end
    failed = 1'b1;
  endtask

  // An untaken branch under data independent timing falls through
  always_comb begin
    if (dit && !exp_cmp_i) begin
      exp_target = id_ex_pipe_i.pc + (id_ex_pipe_i.instr_meta.compressed ? 32'd2 : 32'd4);
    end else begin
      exp_target = id_ex_pipe_i.pc + {{(`EX_XLEN-13){id_ex_pipe_i.branch_offset[11]}},
                                      id_ex_pipe_i.branch_offset, 1'b0};
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checks at the falling edge while inputs and outputs are settled
  ////////////////////////////////////////////////////////////////////////////

  always @(negedge clk) begin
    // What the last rising edge should have done to the EX/WB pipe
    if (seen_edge && prev_reset) begin
      assert ({ex_wb_pipe_i.instr_valid, ex_wb_pipe_i.rf_we, ex_wb_pipe_i.csr_en,
               ex_wb_pipe_i.lsu_en, ex_wb_pipe_i.branch_taken, ex_wb_pipe_i.split} === 6'b0)
        else report_error("EX/WB control fields are not cleared by reset");
    end else if (seen_edge && prev_transfer) begin
      assert (ex_wb_pipe_i.csr_en === exp_wb.csr_en)
        else report_error($sformatf("csr_en is %b, expected %b", ex_wb_pipe_i.csr_en,
                                    exp_wb.csr_en));
      assert (ex_wb_pipe_i.rf_we === exp_wb.rf_we)
        else report_error($sformatf("rf_we is %b, expected %b", ex_wb_pipe_i.rf_we,
                                    exp_wb.rf_we));
      assert (ex_wb_pipe_i.result === exp_wb.result)
        else report_error($sformatf("result is %h, expected %h", ex_wb_pipe_i.result,
                                    exp_wb.result));
      assert (ex_wb_pipe_i === exp_wb)
        else report_error("valid, lsu_en or flags in EX/WB are wrong after a transfer");
    end else if (seen_edge && prev_wb_ready) begin
      if (prev_kill) begin
        assert (ex_wb_pipe_i.instr_valid === 1'b0)
          else report_error("a killed instruction reached writeback");
      end else begin
        assert (ex_wb_pipe_i.instr_valid === 1'b0)
          else report_error("writeback valid without a transfer");
      end
    end else if (seen_edge) begin
      assert (ex_wb_pipe_i === prev_wb)
        else report_error("EX/WB pipe changed under back-pressure");
    end

    // Combinational behavior of the current cycle
    if (!reset_i) begin
      if (ctrl_fsm_i.kill_ex) begin
        assert (ex_ready_i && !ex_valid_i)
          else report_error("kill must give ready high and valid low");
      end else if (ctrl_fsm_i.halt_ex) begin
        assert (!ex_ready_i && !ex_valid_i)
          else report_error("halt must give ready and valid low");
      end else begin
        assert (ex_ready_i == wb_ready_i && ex_valid_i == id_ex_pipe_i.instr_valid)
          else report_error("ready or valid wrong without halt or kill");
      end
      if (id_ex_pipe_i.instr_valid) begin
        assert (dit == prev_dit)
          else report_error("data independent timing mode changed under a valid instruction");
        assert (branch_decision_i === (id_ex_pipe_i.instr_meta.branch && (exp_cmp_i || dit)))
          else report_error($sformatf("branch decision is %b", branch_decision_i));
        if (id_ex_pipe_i.instr_meta.branch) begin
          assert (branch_target_i === exp_target)
            else report_error($sformatf("branch target is %h, expected %h",
                                        branch_target_i, exp_target));
        end
      end
    end

    // Expected EX/WB contents if the next rising edge transfers
    exp_wb = '{
      instr_valid:  1'b1,
      rf_we:        id_ex_pipe_i.rf_we && !(id_ex_pipe_i.lsu_en && lsu_split_i),
      csr_en:       id_ex_pipe_i.csr_en && !csr_illegal_i &&
                    !(X_EXT && id_ex_pipe_i.xif_en && id_ex_pipe_i.xif_meta.accepted),
      lsu_en:       id_ex_pipe_i.lsu_en,
      result:       exp_result_i,
      branch_taken: id_ex_pipe_i.instr_meta.branch && (exp_cmp_i || dit),
      split:        id_ex_pipe_i.lsu_en && lsu_split_i
    };
    prev_transfer = !reset_i && id_ex_pipe_i.instr_valid && !ctrl_fsm_i.halt_ex &&
                    !ctrl_fsm_i.kill_ex && wb_ready_i;
    prev_kill     = ctrl_fsm_i.kill_ex;
    prev_wb_ready = wb_ready_i;
    prev_reset    = reset_i;
    prev_dit      = dit;
    prev_wb       = ex_wb_pipe_i;
    seen_edge     = 1'b1;
  end

endmodule

`default_nettype wire

/* testbench/tb_ex_stage.sv */
// Execute stage testbench

`timescale 1ns/1ns
`default_nettype none

`include "ex_cfg.svh"

module tb_ex_stage;

  import ex_pkg::*;

  localparam int          CLK_PERIOD      = 40;
  localparam int          DRIVE_DELAY     = 5;
  localparam int          RESET_CYCLES    = 16;
  localparam int          NUM_INSTR       = 600;
  // Stalls and bubbles add roughly a sixth to the instruction count
  // A third leaves room for an unlucky stretch of back-pressure
  localparam int          WATCHDOG_CYCLES = RESET_CYCLES + NUM_INSTR + NUM_INSTR / 3;
  localparam bit          X_EXT           = `EX_X_EXT_DEFAULT;
  localparam logic [15:0] LFSR_TAPS       = 16'hB400;

  logic                clk;
  logic                reset_i;
  id_ex_pipe_t         id_ex_pipe;
  ctrl_fsm_t           ctrl_fsm;
  xsecure_ctrl_t       xsecure_ctrl;
  logic                csr_illegal;
  logic                lsu_split;
  logic                wb_ready;
  logic                ex_ready;
  logic                ex_valid;
  logic                branch_decision;
  logic [`EX_XLEN-1:0] branch_target;
  ex_wb_pipe_t         ex_wb_pipe;
  logic [`EX_XLEN-1:0] exp_result;
  logic                exp_cmp;
  logic                check_error;
  logic [15:0]         lfsr_state = 16'd43321;

  ex_stage #(.X_EXT(X_EXT)) dut (
    .clk               (clk),
    .reset_i           (reset_i),
    .id_ex_pipe_i      (id_ex_pipe),
    .ctrl_fsm_i        (ctrl_fsm),
    .xsecure_ctrl_i    (xsecure_ctrl),
    .csr_illegal_i     (csr_illegal),
    .lsu_split_i       (lsu_split),
    .wb_ready_i        (wb_ready),
    .ex_ready_o        (ex_ready),
    .ex_valid_o        (ex_valid),
    .branch_decision_o (branch_decision),
    .branch_target_o   (branch_target),
    .ex_wb_pipe_o      (ex_wb_pipe)
  );

  ex_stage_checker #(.X_EXT(X_EXT)) u_checker (
    .clk               (clk),
    .reset_i           (reset_i),
    .id_ex_pipe_i      (id_ex_pipe),
    .ctrl_fsm_i        (ctrl_fsm),
    .xsecure_ctrl_i    (xsecure_ctrl),
    .csr_illegal_i     (csr_illegal),
    .lsu_split_i       (lsu_split),
    .wb_ready_i        (wb_ready),
    .ex_ready_i        (ex_ready),
    .ex_valid_i        (ex_valid),
    .branch_decision_i (branch_decision),
    .branch_target_i   (branch_target),
    .ex_wb_pipe_i      (ex_wb_pipe),
    .exp_result_i      (exp_result),
    .exp_cmp_i         (exp_cmp),
    .error_o           (check_error)
  );

  ////////////////////////////////////////////////////////////////////////////
  // Random source and reference model
  ////////////////////////////////////////////////////////////////////////////

  // Galois LFSR stepped once per bit handed out
  function automatic logic [31:0] random_bits(input int count);
    logic [31:0] value;
    value = '0;
    for (int i = 0; i < count; i++) begin
      value      = {value[30:0], lfsr_state[0]};
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ LFSR_TAPS) : (lfsr_state >> 1);
    end
    return value;
  endfunction

  // Flipping the sign bits turns a signed compare into an unsigned one
  function automatic logic signed_less(input logic [31:0] a, input logic [31:0] b);
    return (a ^ 32'h8000_0000) < (b ^ 32'h8000_0000);
  endfunction

  function automatic logic model_compare(input alu_op_e op, input logic [31:0] a,
                                         input logic [31:0] b);
    case (op)
      ALU_EQ:  return a == b;
      ALU_NE:  return a != b;
      ALU_LT:  return signed_less(a, b);
      ALU_GE:  return !signed_less(a, b);
      ALU_LTU: return a < b;
      ALU_GEU: return a >= b;
      default: return 1'b0;
    endcase
  endfunction

  function automatic logic [31:0] model_alu(input alu_op_e op, input logic [31:0] a,
                                            input logic [31:0] b);
    int          sh;
    logic [31:0] sign_fill;
    sh        = int'(b[4:0]);
    sign_fill = a[31] ? ~(32'hFFFF_FFFF >> sh) : 32'h0;
    case (op)
      ALU_ADD:  return a + b;
      ALU_SUB:  return a + ~b + 32'd1;
      ALU_AND:  return a & b;
      ALU_OR:   return a | b;
      ALU_XOR:  return a ^ b;
      ALU_SLT:  return {31'd0, signed_less(a, b)};
      ALU_SLTU: return {31'd0, a < b};
      ALU_SLL:  return a << sh;
      ALU_SRL:  return a >> sh;
      ALU_SRA:  return (a >> sh) | sign_fill;
      default:  return {31'd0, model_compare(op, a, b)};
    endcase
  endfunction

  // Loads and stores expect the address a plus b
  always_comb begin
    exp_cmp = model_compare(id_ex_pipe.alu_op, id_ex_pipe.operand_a, id_ex_pipe.operand_b);
    if (id_ex_pipe.lsu_en) begin
      exp_result = id_ex_pipe.operand_a + id_ex_pipe.operand_b;
    end else begin
      exp_result = model_alu(id_ex_pipe.alu_op, id_ex_pipe.operand_a, id_ex_pipe.operand_b);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////

  task automatic issue_instruction();
    logic [31:0] r;
    r = random_bits(4);
    if (r[3:0] == 4'd0) begin
      // A bubble is the only point where the security mode may change
      id_ex_pipe.instr_valid = 1'b0;
      r = random_bits(1);
      xsecure_ctrl.cpuctrl.dataindtiming = r[0];
    end else begin
      id_ex_pipe.instr_valid = 1'b1;
      r = random_bits(32);
      id_ex_pipe.pc        = {r[31:1], 1'b0};
      id_ex_pipe.operand_a = random_bits(32);
      id_ex_pipe.operand_b = random_bits(32);
      r = random_bits(2);
      // Equal operands now and then so EQ and NE see both outcomes
      if (r[1:0] == 2'd0) begin
        id_ex_pipe.operand_b = id_ex_pipe.operand_a;
      end
      r = random_bits(12);
      id_ex_pipe.branch_offset = r[11:0];
      r = random_bits(4);
      id_ex_pipe.alu_op = alu_op_e'(r[3:0]);
      r = random_bits(9);
      id_ex_pipe.alu_en                = r[0];
      id_ex_pipe.lsu_en                = (r[2:1] == 2'd0);
      id_ex_pipe.csr_en                = r[3];
      id_ex_pipe.rf_we                 = r[4];
      id_ex_pipe.xif_en                = r[5];
      id_ex_pipe.xif_meta.accepted     = r[6];
      id_ex_pipe.instr_meta.branch     = r[7];
      id_ex_pipe.instr_meta.compressed = r[8];
    end
  endtask

  // Halt and kill are rare while back-pressure is a little more common
  task automatic drive_controls();
    logic [31:0] r;
    r = random_bits(5);
    ctrl_fsm.halt_ex = (r[4:0] == 5'd0);
    r = random_bits(5);
    ctrl_fsm.kill_ex = (r[4:0] == 5'd0);
    r = random_bits(4);
    wb_ready = (r[3:0] != 4'd0);
    r = random_bits(2);
    csr_illegal = r[0];
    lsu_split   = r[1];
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  initial begin : drive_stimulus
    int   accepted_count;
    logic holding;
    id_ex_pipe   = '0;
    ctrl_fsm     = '0;
    xsecure_ctrl = '0;
    csr_illegal  = 1'b0;
    lsu_split    = 1'b0;
    wb_ready     = 1'b0;
    reset_i      = 1'b1;
    accepted_count = 0;
    holding        = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    #DRIVE_DELAY;
    reset_i = 1'b0;
    while (accepted_count < NUM_INSTR) begin
      // ID holds its instruction until EX takes it
      if (!holding) begin
        issue_instruction();
      end
      drive_controls();
      @(negedge clk);
      if (id_ex_pipe.instr_valid && ex_ready) begin
        accepted_count++;
      end
      holding = id_ex_pipe.instr_valid && !ex_ready;
      @(posedge clk);
      #DRIVE_DELAY;
    end
    // Let the last transfer reach writeback and be checked
    id_ex_pipe.instr_valid = 1'b0;
    ctrl_fsm               = '0;
    wb_ready               = 1'b1;
    repeat (3) @(negedge clk);
    if (check_error) begin
      $display("CHECKS FAILED");
      $fatal(1, "The checker reported a mismatch");
    end else begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

  always @(posedge check_error) begin
    $display("CHECKS FAILED");
    $fatal(1, "Stopping at the first failed check");
  end

  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("CHECKS FAILED");
    $fatal(1, "Timeout: the stimulus did not finish within %0d cycles", WATCHDOG_CYCLES);
  end

endmodule

`default_nettype wire
